// File: relspwedQuant.f
+incdir+test
source/lspPkg.sv
source/splitSum.sv
source/codeAssembler.sv
source/relspwedQuant.sv
test/relspwedQuantTb.sv

// File: test/relspwedQuantModel.svh
`ifndef RELSPWEDQUANT_MODEL_SVH
`define RELSPWEDQUANT_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// constant rom contents
//////////////////////////////////////////////////////////////////////
function automatic logic [coefWidth-1:0] romWord(input logic [addrWidth-1:0] addr);
	logic [31:0] hash;
	logic [candWidth-1:0] entry;
	logic [3:0] coef;
	entry = addr[addrWidth-2:4];
	coef = addr[3:0];
	hash = 32'(addr) * 32'h9e3779b1;
	hash = hash ^ (hash >> 13);
	romWord = hash[27:12];
	// a few entries pushed near the extremes so sums clip
	if (addr[addrWidth-1] == cb1Select && entry == 7'd127)
		romWord = 16'h6000 + 16'(coef);
	else if (addr[addrWidth-1] == cb1Select && entry == 7'd126)
		romWord = 16'ha000 + 16'(coef);
	else if (addr[addrWidth-1] == cb2Select && entry == 7'd31)
		romWord = 16'h5000 + 16'({coef, 4'h0});
	else if (addr[addrWidth-1] == cb2Select && entry == 7'd30)
		romWord = 16'hb000 + 16'(coef);
	else if (addr[addrWidth-1] == cb2Select && entry == 7'd29)
		romWord = 16'h1fff - 16'(coef);  // lands exactly on coefMax with cb1 entry 127
endfunction

// select bit, entry number, coef number from top to bottom
function automatic logic [addrWidth-1:0] romAddress(input logic sel, input int entry,
	input int coef);
	int addr;
	addr = (int'(sel) << (addrWidth - 1)) + (entry << 4) + coef;
	romAddress = addr[addrWidth-1:0];
endfunction

function automatic logic [coefWidth-1:0] satAdd(input logic [coefWidth-1:0] a,
	input logic [coefWidth-1:0] b);
	int sum;
	sum = int'($signed(a)) + int'($signed(b));
	if (sum > int'(coefMax))
		sum = int'(coefMax);
	else if (sum < int'(coefMin))
		sum = int'(coefMin);
	satAdd = sum[coefWidth-1:0];
endfunction

function automatic logic [coefWidth-1:0] packWord0(input logic m,
	input logic [candWidth-1:0] c);
	int word;
	word = (int'(m) << cand0Bits) | int'(c);
	packWord0 = word[coefWidth-1:0];
endfunction

function automatic logic [coefWidth-1:0] packWord1(input logic [indexWidth-1:0] i1,
	input logic [indexWidth-1:0] i2);
	int word;
	word = (int'(i1) << index1Bits) | int'(i2);
	packWord1 = word[coefWidth-1:0];
endfunction

//////////////////////////////////////////////////////////////////////
// expected buffer and code words for one frame
//////////////////////////////////////////////////////////////////////
function automatic void lspRef(input logic m, input logic [candWidth-1:0] c,
	input logic [indexWidth-1:0] i1, input logic [indexWidth-1:0] i2,
	output logic [lpcOrder-1:0][coefWidth-1:0] bufVals,
	output logic [coefWidth-1:0] word0, output logic [coefWidth-1:0] word1);
	int k;
	int idx;
	logic [coefWidth-1:0] first;
	logic [coefWidth-1:0] second;
	for (k = 0; k < lpcOrder; k++)
	begin
		idx = (k < splitPoint) ? int'(i1) : int'(i2);  // lower half index1, upper index2
		first = romWord(romAddress(cb1Select, int'(c), k));
		second = romWord(romAddress(cb2Select, idx, k));
		bufVals[k] = satAdd(first, second);
	end
	word0 = packWord0(m, c);
	word1 = packWord1(i1, i2);
endfunction

`endif

// File: test/relspwedQuantTb.sv
`timescale 1ns/1ns

module relspwedQuantTb
	import lspPkg::*;
();

	localparam int clkPeriod = 100;
	localparam int frameLatency = 17;   // start edge to done
	localparam int maxCycles = 40 * 30;

	`include "relspwedQuantModel.svh"

	logic clk;
	logic reset;
	logic start;
	logic mode;
	logic [candWidth-1:0] cand;
	logic [indexWidth-1:0] index1;
	logic [indexWidth-1:0] index2;
	logic [addrWidth-1:0] lowRomAddr;
	logic [addrWidth-1:0] highRomAddr;
	logic [coefWidth-1:0] lowRomData = '0;
	logic [coefWidth-1:0] highRomData = '0;
	logic bufWriteEn;
	logic [addrWidth-1:0] bufWriteAddr;
	logic [coefWidth-1:0] bufWriteData;
	lspCode0T codeWord0;
	logic [coefWidth-1:0] codeWord1;
	logic done;

	// scoreboard state
	string testName = "reset";
	logic [lpcOrder-1:0][coefWidth-1:0] expBuf;
	logic [coefWidth-1:0] expWord0;
	logic [coefWidth-1:0] expWord1;
	logic [coefWidth-1:0] heldWord0 = '0;
	logic [coefWidth-1:0] heldWord1 = '0;
	logic expMode;
	logic [candWidth-1:0] expCand;
	bit frameOpen = 1'b0;
	int writeCount[lpcOrder];
	int satHits = 0;
	int doneCount = 0;
	int acceptCount = 0;
	int cycleCount = 0;
	int valueErrors = 0;
	int sequenceErrors = 0;
	int timeouts = 0;
	int seed;

	relspwedQuant i_dut (
		.clk(clk), .reset(reset), .start(start), .mode(mode), .cand(cand),
		.index1(index1), .index2(index2),
		.lowRomAddr(lowRomAddr), .lowRomData(lowRomData),
		.highRomAddr(highRomAddr), .highRomData(highRomData),
		.bufWriteEn(bufWriteEn), .bufWriteAddr(bufWriteAddr), .bufWriteData(bufWriteData),
		.codeWord0(codeWord0), .codeWord1(codeWord1), .done(done)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// registered roms with one cycle latency
	always @(posedge clk)
		lowRomData <= romWord(lowRomAddr);

	always @(posedge clk)
		highRomData <= romWord(highRomAddr);

	//////////////////////////////////////////////////////////////////////
	// reporting
	//////////////////////////////////////////////////////////////////////
	task automatic reportValue(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[ERROR] %s %s expected %0h actual %0h", testName, what, expected, actual);
		valueErrors++;
	endtask

	task automatic reportProblem(input string msg);
		$display("%s: %s", testName, msg);
		sequenceErrors++;
	endtask

	task automatic finishRun();
		$display("error counts: value %0d, sequence %0d, timeout %0d",
			valueErrors, sequenceErrors, timeouts);
		if (valueErrors + sequenceErrors + timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// checking process
	//////////////////////////////////////////////////////////////////////
	task automatic checkWrite();
		int offset;
		bit inRange;
		offset = int'(bufWriteAddr) - int'(bufBase);
		inRange = (offset >= 0 && offset < lpcOrder);
		assert (frameOpen) else reportProblem("buffer write with no frame running");
		assert (inRange)
			else reportProblem($sformatf("write to address %0h outside the buffer",
				bufWriteAddr));
		if (frameOpen && inRange)
		begin
			assert (bufWriteData == expBuf[offset])
				else reportValue($sformatf("coef%0d", offset), expBuf[offset], bufWriteData);
			if (bufWriteData == expBuf[offset] && (bufWriteData == coefMax ||
				bufWriteData == coefMin))
				satHits++;
			writeCount[offset]++;
		end
	endtask

	task automatic checkFrameEnd();
		int k;
		assert (frameOpen) else reportProblem("done pulse with no accepted start");
		for (k = 0; k < lpcOrder; k++)
		begin
			assert (writeCount[k] == 1)
				else reportProblem($sformatf("coef %0d written %0d times", k, writeCount[k]));
			writeCount[k] = 0;
		end
		assert (codeWord0.raw == expWord0) else reportValue("codeWord0", expWord0, codeWord0);
		assert (codeWord0.field.mode == expMode)
			else reportValue("codeWord0.mode", expMode, codeWord0.field.mode);
		assert (codeWord0.field.cand == expCand)
			else reportValue("codeWord0.cand", expCand, codeWord0.field.cand);
		assert (codeWord1 == expWord1) else reportValue("codeWord1", expWord1, codeWord1);
		heldWord0 = expWord0;
		heldWord1 = expWord1;
		frameOpen = 1'b0;
		doneCount++;
	endtask

	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (bufWriteEn)
				checkWrite();
			if (done)
				checkFrameEnd();
			else
			begin
				// words hold between done pulses
				assert (codeWord0.raw == heldWord0)
					else reportValue("hold0", heldWord0, codeWord0);
				assert (codeWord1 == heldWord1)
					else reportValue("hold1", heldWord1, codeWord1);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////
	task automatic runFrame(input string name, input logic m, input logic [candWidth-1:0] c,
		input logic [indexWidth-1:0] i1, input logic [indexWidth-1:0] i2, input bit poke);
		int startCycle;
		testName = name;
		lspRef(m, c, i1, i2, expBuf, expWord0, expWord1);
		expMode = m;
		expCand = c;
		frameOpen = 1'b1;
		acceptCount++;
		start = 1'b1;
		mode = m;
		cand = c;
		index1 = i1;
		index2 = i2;
		@(posedge clk);
		#5;
		start = 1'b0;
		startCycle = cycleCount;
		if (poke)
		begin
			repeat (5) @(posedge clk);
			#5;
			start = 1'b1;  // lands while busy
			mode = ~m;
			cand = ~c;
			index1 = ~i1;
			index2 = ~i2;
			@(posedge clk);
			#5;
			start = 1'b0;
		end
		do
			@(negedge clk);
		while (!done && cycleCount - startCycle < 2 * frameLatency);
		assert (done) else reportProblem("no done pulse after an accepted start");
		assert (cycleCount - startCycle == frameLatency)
			else reportProblem($sformatf("done came %0d cycles after start",
				cycleCount - startCycle));
		@(posedge clk);
		#5;
	endtask

	initial
	begin
		int hitsBefore;
		int rnd;
		int n;
		seed = 32'h8c1a2e57;
		reset = 1'b1;
		start = 1'b0;
		mode = 1'b0;
		cand = '0;
		index1 = '0;
		index2 = '0;
		repeat (8) @(posedge clk);
		#5;
		reset = 1'b0;
		testName = "idle";
		repeat (4)
		begin
			@(negedge clk);
			assert (!done && !bufWriteEn && codeWord0.raw == '0 && codeWord1 == '0)
				else reportProblem("outputs not quiet after reset");
		end
		@(posedge clk);
		#5;
		runFrame("zeroFrame", 1'b0, 7'd0, 5'd0, 5'd0, 1'b0);
		runFrame("mixedFrame", 1'b1, 7'd85, 5'd10, 5'd21, 1'b0);
		hitsBefore = satHits;
		runFrame("satHigh", 1'b0, 7'd127, 5'd31, 5'd31, 1'b0);
		runFrame("satLow", 1'b1, 7'd126, 5'd30, 5'd30, 1'b0);
		assert (satHits - hitsBefore == 2 * lpcOrder)
			else reportProblem("clipped results missing in saturation frames");
		runFrame("satEdge", 1'b1, 7'd127, 5'd29, 5'd30, 1'b0);
		runFrame("busyStart", 1'b0, 7'd3, 5'd7, 5'd12, 1'b1);
		for (n = 0; n < 30; n++)
		begin
			rnd = $random(seed);
			runFrame($sformatf("random%0d", n), rnd[20], rnd[6:0], rnd[11:7], rnd[16:12],
				rnd[21]);
			repeat (rnd[23:22])
			begin
				@(posedge clk);
				#5;
			end
		end
		testName = "drain";
		repeat (20) @(negedge clk);  // long enough for a wrongly started frame
		assert (doneCount == acceptCount)
			else reportProblem($sformatf("%0d done pulses for %0d accepted starts",
				doneCount, acceptCount));
		finishRun();
	end

	// run limit
	initial
	begin
		while (cycleCount < maxCycles)
		begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: run did not finish within %0d cycles", maxCycles);
		timeouts++;
		finishRun();
	end

endmodule

// File: source/relspwedQuant.sv
`timescale 1ns/1ns

module relspwedQuant
	import lspPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic mode,
	input  logic [candWidth-1:0] cand,
	input  logic [indexWidth-1:0] index1,
	input  logic [indexWidth-1:0] index2,

	output logic [addrWidth-1:0] lowRomAddr,
	input  logic [coefWidth-1:0] lowRomData,
	output logic [addrWidth-1:0] highRomAddr,
	input  logic [coefWidth-1:0] highRomData,

	output logic bufWriteEn,
	output logic [addrWidth-1:0] bufWriteAddr,
	output logic [coefWidth-1:0] bufWriteData,

	output lspCode0T codeWord0,
	output logic [coefWidth-1:0] codeWord1,
	output logic done
);

	logic busy;
	logic accept;
	logic modeReg;
	logic [candWidth-1:0] candReg;
	logic [indexWidth-1:0] index1Reg;
	logic [indexWidth-1:0] index2Reg;
	logic lowStrobe, highStrobe;
	logic [coefIdxWidth-1:0] lowCoef, highCoef;
	logic [coefWidth-1:0] lowValue, highValue;
	logic lowDone, highDone;

	assign accept = start && !busy;  // start while busy is dropped

	always_ff @(posedge clk)
	begin
		if (reset)
			busy <= 1'b0;
		else if (accept)
			busy <= 1'b1;
		else if (done)
			busy <= 1'b0;
	end

	// frame inputs held for the whole frame
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			modeReg <= mode;
			candReg <= cand;
			index1Reg <= index1;
			index2Reg <= index2;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// two halves, lower uses index1, upper index2
	//////////////////////////////////////////////////////////////////////
	splitSum #(.firstCoef(0)) iLow (
		.clk(clk), .reset(reset), .start(accept), .cand(candReg), .index(index1Reg),
		.romData(lowRomData), .romAddr(lowRomAddr),
		.resultStrobe(lowStrobe), .resultCoef(lowCoef), .resultValue(lowValue),
		.halfDone(lowDone)
	);

	splitSum #(.firstCoef(splitPoint)) iHigh (
		.clk(clk), .reset(reset), .start(accept), .cand(candReg), .index(index2Reg),
		.romData(highRomData), .romAddr(highRomAddr),
		.resultStrobe(highStrobe), .resultCoef(highCoef), .resultValue(highValue),
		.halfDone(highDone)
	);

	codeAssembler iAssembler (
		.clk(clk), .reset(reset), .start(accept), .mode(modeReg), .cand(candReg),
		.index1(index1Reg), .index2(index2Reg),
		.lowStrobe(lowStrobe), .lowCoef(lowCoef), .lowValue(lowValue), .lowDone(lowDone),
		.highStrobe(highStrobe), .highCoef(highCoef), .highValue(highValue),
		.highDone(highDone),
		.bufWriteEn(bufWriteEn), .bufWriteAddr(bufWriteAddr), .bufWriteData(bufWriteData),
		.codeWord0(codeWord0), .codeWord1(codeWord1), .done(done)
	);

endmodule

// File: source/codeAssembler.sv
`timescale 1ns/1ns

module codeAssembler
	import lspPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic mode,
	input  logic [candWidth-1:0] cand,
	input  logic [indexWidth-1:0] index1,
	input  logic [indexWidth-1:0] index2,

	input  logic lowStrobe,
	input  logic [coefIdxWidth-1:0] lowCoef,
	input  logic [coefWidth-1:0] lowValue,
	input  logic lowDone,

	input  logic highStrobe,
	input  logic [coefIdxWidth-1:0] highCoef,
	input  logic [coefWidth-1:0] highValue,
	input  logic highDone,

	output logic bufWriteEn,
	output logic [addrWidth-1:0] bufWriteAddr,
	output logic [coefWidth-1:0] bufWriteData,

	output lspCode0T codeWord0,
	output logic [coefWidth-1:0] codeWord1,
	output logic done
);

	logic pendingValid;
	logic pendingLoad;
	logic [coefIdxWidth-1:0] pendingCoef;
	logic [coefWidth-1:0] pendingValue;
	logic [coefIdxWidth-1:0] selCoef;
	logic lowFin;
	logic highFin;
	logic bothFin;
	logic fire;
	lspCode0T word0;
	logic [coefWidth-1:0] word1;

	// both halves strobe together, upper one waits a cycle
	assign pendingLoad = lowStrobe && highStrobe;

	//////////////////////////////////////////////////////////////////////
	// scratch write port
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		bufWriteEn = pendingValid || lowStrobe || highStrobe;
		if (pendingValid)
		begin
			selCoef = pendingCoef;
			bufWriteData = pendingValue;
		end
		else if (lowStrobe)
		begin
			selCoef = lowCoef;
			bufWriteData = lowValue;
		end
		else
		begin
			selCoef = highCoef;
			bufWriteData = highValue;
		end
		bufWriteAddr = bufBase + addrWidth'(selCoef);
	end

	always_ff @(posedge clk)
	begin
		if (pendingLoad)
		begin
			pendingCoef <= highCoef;
			pendingValue <= highValue;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// completion and code words
	//////////////////////////////////////////////////////////////////////
	assign bothFin = (lowFin || lowDone) && (highFin || highDone);
	assign fire = bothFin && !pendingLoad;  // a held entry drains this cycle

	always_comb
	begin
		word0.field.pad = '0;
		word0.field.mode = mode;
		word0.field.cand = cand;
	end

	assign word1 = (coefWidth'(index1) << index1Bits) | coefWidth'(index2);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pendingValid <= 1'b0;
			lowFin <= 1'b0;
			highFin <= 1'b0;
			done <= 1'b0;
			codeWord0 <= '0;
			codeWord1 <= '0;
		end
		else
		begin
			pendingValid <= pendingLoad;
			done <= fire;
			if (start || fire)
			begin
				lowFin <= 1'b0;
				highFin <= 1'b0;
			end
			else
			begin
				if (lowDone)
					lowFin <= 1'b1;
				if (highDone)
					highFin <= 1'b1;
			end
			if (fire)
			begin
				codeWord0 <= word0;
				codeWord1 <= word1;
			end
		end
	end

	pendingNoOverrun: assert property (@(posedge clk) disable iff (reset)
		pendingLoad |-> !pendingValid)
		else $error("pending write loaded while still full");

	writeDistinct: assert property (@(posedge clk) disable iff (reset)
		bufWriteEn |=> !bufWriteEn || bufWriteAddr != $past(bufWriteAddr))
		else $error("same buffer coefficient written in back to back cycles");

endmodule

// File: source/splitSum.sv
`timescale 1ns/1ns

module splitSum
	import lspPkg::*;
#(
	parameter int firstCoef = 0
)
(
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic [candWidth-1:0] cand,
	input  logic [indexWidth-1:0] index,

	input  logic [coefWidth-1:0] romData,
	output logic [addrWidth-1:0] romAddr,

	output logic resultStrobe,
	output logic [coefIdxWidth-1:0] resultCoef,
	output logic [coefWidth-1:0] resultValue,
	output logic halfDone
);

	logic active;
	logic [1:0] phase;    // 0 cb1 addr, 1 cb2 addr, 2 add
	logic [coefIdxWidth-1:0] coefCnt;
	logic [coefWidth-1:0] cb1Coef;
	logic [coefWidth:0] wideSum;
	logic [coefWidth-1:0] satSum;
	logic lastCoef;

	assign lastCoef = (coefCnt == coefIdxWidth'(firstCoef + splitPoint - 1));

	//////////////////////////////////////////////////////////////////////
	// constant rom address
	//////////////////////////////////////////////////////////////////////
	always_comb
	begin
		if (phase == 2'd1)
			romAddr = {cb2Select, entryWidth'(index), coefCnt};
		else
			romAddr = {cb1Select, entryWidth'(cand), coefCnt};
	end

	// sign extended add, clip on overflow
	assign wideSum = {cb1Coef[coefWidth-1], cb1Coef} + {romData[coefWidth-1], romData};

	always_comb
	begin
		if (wideSum[coefWidth] != wideSum[coefWidth-1])
			satSum = wideSum[coefWidth] ? coefMin : coefMax;
		else
			satSum = wideSum[coefWidth-1:0];
	end

	//////////////////////////////////////////////////////////////////////
	// three phase loop over five coefficients
	//////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			active <= 1'b0;
			phase <= 2'd0;
			coefCnt <= coefIdxWidth'(firstCoef);
			resultStrobe <= 1'b0;
			halfDone <= 1'b0;
		end
		else
		begin
			resultStrobe <= 1'b0;
			halfDone <= resultStrobe && !active;  // last strobe leaves active low
			if (start && !active)
			begin
				active <= 1'b1;
				phase <= 2'd0;
				coefCnt <= coefIdxWidth'(firstCoef);
			end
			else if (active)
			begin
				case (phase)
					2'd0:
						phase <= 2'd1;
					2'd1:
						phase <= 2'd2;
					default:
					begin
						phase <= 2'd0;
						resultStrobe <= 1'b1;
						coefCnt <= coefCnt + 1'b1;
						if (lastCoef)
							active <= 1'b0;
					end
				endcase
			end
		end
	end

	// first stage coef arrives while cb2 address is out
	always_ff @(posedge clk)
	begin
		if (active && phase == 2'd1)
			cb1Coef <= romData;
		if (active && phase == 2'd2)
		begin
			resultValue <= satSum;
			resultCoef <= coefCnt;
		end
	end

	coefBound: assert property (@(posedge clk) disable iff (reset)
		coefCnt <= coefIdxWidth'(firstCoef + splitPoint))
		else $error("splitSum coef counter ran past its half");

endmodule

// File: source/lspPkg.sv
package lspPkg;

	//////////////////////////////////////////////////////////////////////
	// LSP order and split
	//////////////////////////////////////////////////////////////////////
	localparam int lpcOrder = 10;   // M
	localparam int splitPoint = 5;  // NC, first coef of upper half

	// codebook sizes
	localparam int cb1Entries = 128;
	localparam int cb2Entries = 32;

	// code word packing shifts
	localparam int cand0Bits = 7;   // NC0_B
	localparam int index1Bits = 5;  // NC1_B

	//////////////////////////////////////////////////////////////////////
	// widths and addresses
	//////////////////////////////////////////////////////////////////////
	localparam int addrWidth = 12;
	localparam int coefWidth = 16;
	localparam int candWidth = $clog2(cb1Entries);
	localparam int indexWidth = $clog2(cb2Entries);
	localparam int coefIdxWidth = $clog2(lpcOrder);
	localparam int entryWidth = addrWidth - 1 - coefIdxWidth;  // between select bit and coef

	// table select, top bit of a constant address
	localparam logic cb1Select = 1'b0;
	localparam logic cb2Select = 1'b1;

	// scratch buffer, low bits take the coef number
	localparam logic [addrWidth-1:0] bufBase = 12'h3a0;

	// saturation limits for the 16 bit add
	localparam logic signed [coefWidth-1:0] coefMax = 16'sh7fff;
	localparam logic signed [coefWidth-1:0] coefMin = 16'sh8000;

	// first code analysis word, raw or as mode and candidate
	typedef union packed
	{
		logic [coefWidth-1:0] raw;
		struct packed
		{
			logic [coefWidth-cand0Bits-2:0] pad;
			logic mode;
			logic [cand0Bits-1:0] cand;
		} field;
	} lspCode0T;

endpackage
